/* sm83_core.f */
verilog/sm83_pkg.sv
verilog/sm83_sequencer.sv
verilog/sm83_decoder.sv
verilog/sm83_addr_unit.sv
verilog/sm83_alu.sv
verilog/sm83_regfile.sv
verilog/sm83_core.sv
bench/tb_sm83_core.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sm83_core.f
TB_TOP    ?= tb_sm83_core
RTL_TOP   ?= sm83_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || (echo "Run did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_sm83_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sm83_core import sm83_pkg::*; ();

    localparam logic [ADDR_W-1:0] RESET_PC = 16'h0150;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 4;
    localparam int SEED       = 47385;
    localparam int NUM_TESTS  = 5;
    localparam int PROG_LEN   = 256;
    localparam int K_ANY      = 0;      // Address not predicted
    localparam int K_ADDR     = 1;
    localparam int K_WRITE    = 2;

    logic              clk = 1'b0;
    logic              rst;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] d_in;
    logic [DATA_W-1:0] d_out;
    logic              write;

    logic [DATA_W-1:0] mem     [0:65535];   // Memory seen by the DUT
    logic [DATA_W-1:0] ref_mem [0:65535];   // Memory of the reference model
    logic [7:0]        prog [NUM_TESTS][PROG_LEN];
    int                prog_len [NUM_TESTS];
    int                n_ops [NUM_TESTS];
    int                trace_len [NUM_TESTS];
    int                kind_q [$];          // Expected bus activity for each step
    logic [ADDR_W-1:0] addr_q [$];
    logic [DATA_W-1:0] data_q [$];
    int                errors;
    int                failed_tests;
    int                timeout_ns;
    int                gen_t;
    int                gen_pc;

    sm83_core #(.RESET_PC(RESET_PC)) sm83_core_i (
        .clk(clk), .rst(rst), .addr(addr), .d_in(d_in), .d_out(d_out), .write(write)
    );

    assign d_in = mem[addr];    // Combinational read

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [DATA_W-1:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[15:8] ^ a[7:0] ^ 8'ha5;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset fetch";
            1:       return "load and store";
            2:       return "alu";
            3:       return "inc dec";
            default: return "jump";
        endcase
    endfunction

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_write(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Program generation
    function automatic logic [2:0] pick_reg();
        logic [2:0] r;
        r = 3'($urandom_range(0, 6));
        return (r == 3'd6) ? 3'd7 : r;  // Skip the (HL) code
    endfunction

    function automatic logic [ADDR_W-1:0] here();
        return ADDR_W'(RESET_PC + gen_pc);
    endfunction

    task automatic put_byte(input logic [7:0] b);
        prog[gen_t][gen_pc] = b;
        gen_pc++;
    endtask

    task automatic put_op(input logic [7:0] op);
        put_byte(op);
        n_ops[gen_t]++;
    endtask

    task automatic put_ld_imm(input logic [2:0] r, input logic [7:0] n);
        put_op({2'b00, r, 3'b110});
        put_byte(n);
    endtask

    task automatic put_random_load();
        case ($urandom_range(0, 2))
            0:       put_ld_imm(pick_reg(), 8'($urandom));
            1:       put_op({2'b01, pick_reg(), pick_reg()});
            default: put_op({2'b01, pick_reg(), 3'b110});  // LD r,(HL)
        endcase
    endtask

    task automatic put_store_all();
        for (int i = 0; i < 7; i++) begin
            put_op({5'b01110, (i == 6) ? 3'd7 : 3'(i)});
        end
    endtask

    task automatic put_alu();
        logic [2:0] op;
        op = 3'($urandom);
        if ($urandom_range(0, 1) == 0) begin
            put_op({2'b10, op, pick_reg()});
        end else begin
            put_op({2'b11, op, 3'b110});
            put_byte(8'($urandom));
        end
    endtask

    task automatic put_jp(input logic [ADDR_W-1:0] target);
        put_op(8'hc3);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
    endtask

    task automatic gen_program(input int t);
        logic [2:0]        r;
        logic              dec;
        int                gap;
        logic [ADDR_W-1:0] target;
        gen_t    = t;
        gen_pc   = 0;
        n_ops[t] = 0;
        case (t)
            0: begin
                repeat (6) begin
                    if ($urandom_range(0, 1) == 0) put_op(NOP);
                    else put_op({2'b01, pick_reg(), pick_reg()});
                end
                put_ld_imm(3'd7, 8'($urandom));
                put_ld_imm(3'd4, 8'hc0);
                put_ld_imm(3'd5, 8'($urandom));
                put_op(8'h77);                  // First store
            end
            1: begin
                repeat (8) begin
                    repeat ($urandom_range(1, 4)) put_random_load();
                    put_store_all();
                end
            end
            2: begin
                for (int i = 0; i < 7; i++) put_ld_imm((i == 6) ? 3'd7 : 3'(i), 8'($urandom));
                repeat (24) begin
                    put_alu();
                    put_op(8'h77);
                end
            end
            3: begin
                repeat (16) begin
                    r   = pick_reg();
                    dec = 1'($urandom);
                    case ($urandom_range(0, 2))
                        0:       put_ld_imm(r, 8'hff);
                        1:       put_ld_imm(r, 8'h00);
                        default: put_ld_imm(r, 8'($urandom));
                    endcase
                    repeat ($urandom_range(1, 3)) put_op({2'b00, r, 2'b10, dec});
                    put_op({5'b01110, r});
                end
            end
            default: begin
                repeat (10) begin
                    put_random_load();
                    put_op(8'h77);
                    gap    = int'($urandom_range(0, 5));
                    target = ADDR_W'(here() + 3 + gap);
                    put_jp(target);
                    repeat (gap) put_byte(8'($urandom));   // Jumped over
                end
            end
        endcase
        target = here();
        put_jp(target);                         // Park on a jump to itself
        prog_len[t] = gen_pc;
    endtask

    // Reference model
    task automatic expect_cycle(input int kind, input logic [ADDR_W-1:0] a,
                                input logic [DATA_W-1:0] d);
        kind_q.push_back(kind);
        addr_q.push_back(a);
        data_q.push_back(d);
    endtask

    function automatic logic [DATA_W-1:0] alu_result(input alu_op_t op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, inout logic cy);
        int sum;
        sum = 0;
        case (op)
            ALU_ADD:         sum = int'(a) + int'(b);
            ALU_ADC:         sum = int'(a) + int'(b) + int'(cy);
            ALU_SUB, ALU_CP: sum = int'(a) - int'(b);
            ALU_SBC:         sum = int'(a) - int'(b) - int'(cy);
            default: ;
        endcase
        case (op)
            ALU_ADD, ALU_ADC: cy = (sum > 255);
            ALU_AND:          cy = 1'b0;
            ALU_XOR:          cy = 1'b0;
            ALU_OR:           cy = 1'b0;
            default:          cy = (sum < 0);   // Borrow
        endcase
        case (op)
            ALU_AND: return a & b;
            ALU_XOR: return a ^ b;
            ALU_OR:  return a | b;
            ALU_CP:  return a;
            default: return 8'(sum);
        endcase
    endfunction

    task automatic run_model(input int t);
        logic [DATA_W-1:0] regs [8];
        logic              cy;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] hl;
        logic [7:0]        op;
        logic [2:0]        d;
        logic [2:0]        s;
        logic [DATA_W-1:0] lo;
        int                start;
        start = kind_q.size();
        for (int a = 0; a < 65536; a++) ref_mem[a] = fill_byte(ADDR_W'(a));
        for (int i = 0; i < prog_len[t]; i++) ref_mem[ADDR_W'(RESET_PC + i)] = prog[t][i];
        for (int i = 0; i < 8; i++) regs[i] = '0;
        cy = 1'b0;
        pc = RESET_PC;
        expect_cycle(K_ADDR, pc, '0);          // Fetch right after reset
        for (int n = 0; n < n_ops[t] + 2; n++) begin
            op = ref_mem[pc];
            d  = op[5:3];
            s  = op[2:0];
            hl = {regs[4], regs[5]};
            pc++;
            case (op[7:6])
                2'b00: begin
                    if (d != 3'd6 && s == 3'd6) begin          // LD r,n
                        expect_cycle(K_ADDR, pc, '0);
                        regs[d] = ref_mem[pc];
                        pc++;
                    end else if (d != 3'd6 && s[2:1] == 2'b10) begin
                        regs[d] = s[0] ? regs[d] - 8'd1 : regs[d] + 8'd1;
                    end
                end
                2'b01: begin
                    if (s == 3'd6 && d != 3'd6) begin          // LD r,(HL)
                        expect_cycle(K_ADDR, hl, '0);
                        regs[d] = ref_mem[hl];
                    end else if (d == 3'd6 && s != 3'd6) begin // LD (HL),r
                        expect_cycle(K_WRITE, hl, regs[s]);
                        ref_mem[hl] = regs[s];
                    end else if (s != 3'd6) begin
                        regs[d] = regs[s];
                    end
                end
                2'b10: begin
                    if (s != 3'd6) regs[7] = alu_result(alu_op_t'(d), regs[7], regs[s], cy);
                end
                default: begin
                    if (s == 3'd6) begin
                        expect_cycle(K_ADDR, pc, '0);
                        regs[7] = alu_result(alu_op_t'(d), regs[7], ref_mem[pc], cy);
                        pc++;
                    end else if (op == 8'hc3) begin
                        expect_cycle(K_ADDR, pc, '0);
                        lo = ref_mem[pc];
                        pc++;
                        expect_cycle(K_ADDR, pc, '0);
                        pc = {ref_mem[pc], lo};
                        expect_cycle(K_ANY, '0, '0);            // PC reload
                    end
                end
            endcase
            expect_cycle(K_ADDR, pc, '0);      // Next opcode fetch
        end
        trace_len[t] = kind_q.size() - start;
    endtask

    task automatic run_test(input int t);
        int                k;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        int                errs_before;
        errs_before = errors;
        @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < 65536; i++) mem[i] = fill_byte(ADDR_W'(i));
        for (int i = 0; i < prog_len[t]; i++) mem[ADDR_W'(RESET_PC + i)] = prog[t][i];
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_write(write, 1'b0, "write during reset");
        end
        @(posedge clk);
        #1 rst = 1'b1;
        for (int c = 0; c < trace_len[t]; c++) begin
            k = kind_q.pop_front();
            a = addr_q.pop_front();
            d = data_q.pop_front();
            @(negedge clk);
            check_write(write, k == K_WRITE, "write strobe");
            if (k != K_ANY) check_addr(addr, a, (k == K_WRITE) ? "store address" : "bus address");
            if (k == K_WRITE) check_data(d_out, d, "store data");
            if (write) mem[addr] = d_out;      // Store lands before the next read
        end
        if (errors != errs_before) failed_tests++;
        $display("test %0d %s: %s, %0d cycles, %0d errors", t + 1, test_name(t),
                 (errors == errs_before) ? "pass" : "fail", trace_len[t], errors - errs_before);
    endtask

    initial begin
        int total;
        rst          = 1'b0;
        errors       = 0;
        failed_tests = 0;
        timeout_ns   = 0;
        total        = 0;
        void'($urandom(SEED));
        for (int t = 0; t < NUM_TESTS; t++) begin
            gen_program(t);
            run_model(t);
            total += trace_len[t] + RST_CYCLES + 2;
        end
        timeout_ns = total * CLK_PERIOD + 100;
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog armed once all traces are known
    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/sm83_core.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_core import sm83_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = 16'h0000
) (
    input  logic              clk,
    input  logic              rst,
    output logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] d_in,
    output logic [DATA_W-1:0] d_out,
    output logic              write
);

    // Control from the decoder
    logic    done;
    ab_sel_t ab_sel;
    reg8_t   s_db;
    reg8_t   t_db;
    r_wb_t   r_wb;
    alu_op_t alu_op;
    acc_t    acc_sel;
    arg_t    arg_sel;
    logic    inc_pc;
    logic    load_pc;

    logic [7:0]        ir;
    step_t             step;
    logic [ADDR_W-1:0] hl;
    logic [ADDR_W-1:0] wz;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] arg;
    logic              c_flag;
    logic [DATA_W-1:0] alu_res;
    flags_t            alu_flags;

    sm83_sequencer seq_i (
        .clk(clk), .rst(rst), .done(done), .d_in(d_in), .ir(ir), .step(step)
    );

    sm83_decoder dec_i (
        .ir(ir), .step(step), .done(done), .ab_sel(ab_sel),
        .s_db(s_db), .t_db(t_db), .r_wb(r_wb), .alu_op(alu_op),
        .acc_sel(acc_sel), .arg_sel(arg_sel),
        .inc_pc(inc_pc), .load_pc(load_pc), .write(write)
    );

    sm83_addr_unit #(.RESET_PC(RESET_PC)) addr_i (
        .clk(clk), .rst(rst), .ab_sel(ab_sel), .hl(hl), .wz(wz),
        .inc_pc(inc_pc), .load_pc(load_pc), .addr(addr)
    );

    sm83_alu alu_i (
        .op(alu_op), .acc(acc), .arg(arg), .c_in(c_flag),
        .res(alu_res), .f_out(alu_flags)
    );

    sm83_regfile rf_i (
        .clk(clk), .rst(rst), .s_db(s_db), .t_db(t_db), .r_wb(r_wb),
        .acc_sel(acc_sel), .arg_sel(arg_sel), .d_in(d_in),
        .alu_res(alu_res), .alu_flags(alu_flags),
        .db(d_out),             // Store data is the internal bus
        .acc(acc), .arg(arg), .c_flag(c_flag), .hl(hl), .wz(wz)
    );

endmodule

`default_nettype wire

/* verilog/sm83_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_regfile import sm83_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  reg8_t             s_db,
    input  reg8_t             t_db,
    input  r_wb_t             r_wb,
    input  acc_t              acc_sel,
    input  arg_t              arg_sel,
    input  logic [DATA_W-1:0] d_in,
    input  logic [DATA_W-1:0] alu_res,
    input  flags_t            alu_flags,
    output logic [DATA_W-1:0] db,
    output logic [DATA_W-1:0] acc,
    output logic [DATA_W-1:0] arg,
    output logic              c_flag,
    output logic [ADDR_W-1:0] hl,
    output logic [ADDR_W-1:0] wz
);

    logic [DATA_W-1:0] rf [Z:A];    // Z, W, B, C, D, E, H, L, A
    logic [DATA_W-1:0] wb;
    flags_t            flags;

    // Internal data bus
    always_comb begin
        case (s_db)
            MEM:     db = d_in;
            NONE:    db = '0;
            default: db = rf[s_db];
        endcase
    end

    assign wb     = (r_wb == WB_ALU) ? alu_res : db;
    assign acc    = (acc_sel == ACC_A) ? rf[A] : db;
    assign arg    = (arg_sel == ARG_ONE) ? DATA_W'(1) : db;
    assign c_flag = flags.c;
    assign hl     = {rf[H], rf[L]};
    assign wz     = {rf[W], rf[Z]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = Z; i <= A; i++) begin
                rf[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (t_db != NONE && t_db != MEM) begin
                rf[t_db] <= wb;
            end
            if (r_wb == WB_ALU) begin
                flags.z <= alu_flags.z;
                flags.n <= alu_flags.n;
                flags.h <= alu_flags.h;
                // INC and DEC leave carry alone
                flags.c <= (arg_sel == ARG_ONE) ? flags.c : alu_flags.c;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sm83_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_alu import sm83_pkg::*; (
    input  alu_op_t           op,
    input  logic [DATA_W-1:0] acc,
    input  logic [DATA_W-1:0] arg,
    input  logic              c_in,
    output logic [DATA_W-1:0] res,
    output flags_t            f_out
);

    logic [DATA_W-1:0] addend;
    logic [DATA_W-1:0] sum;
    logic              is_sub;
    logic              cy0;     // Into bit 0
    logic              cy4;     // Out of the low nibble
    logic              cy8;     // Out of bit 7

    assign is_sub = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
    assign addend = is_sub ? ~arg : arg;    // a - b = a + ~b + 1

    always_comb begin
        case (op)
            ALU_ADC:         cy0 = c_in;
            ALU_SBC:         cy0 = ~c_in;   // Borrow in becomes a missing +1
            ALU_SUB, ALU_CP: cy0 = 1'b1;
            default:         cy0 = 1'b0;
        endcase
    end

    // Nibble split adder so the half carry falls out directly
    assign {cy4, sum[3:0]} = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'b0, cy0};
    assign {cy8, sum[DATA_W-1:4]} = {1'b0, acc[DATA_W-1:4]} + {1'b0, addend[DATA_W-1:4]}
                                  + {{(DATA_W-4){1'b0}}, cy4};

    always_comb begin
        res     = sum;
        f_out.n = is_sub;
        f_out.h = cy4 ^ is_sub;     // Borrow sense for subtracts
        f_out.c = cy8 ^ is_sub;
        case (op)
            ALU_AND: begin
                res     = acc & arg;
                f_out.h = 1'b1;
                f_out.c = 1'b0;
            end
            ALU_XOR: begin
                res     = acc ^ arg;
                f_out.h = 1'b0;
                f_out.c = 1'b0;
            end
            ALU_OR: begin
                res     = acc | arg;
                f_out.h = 1'b0;
                f_out.c = 1'b0;
            end
            default: ;
        endcase
        f_out.z = (res == '0);
    end

endmodule

`default_nettype wire

/* verilog/sm83_addr_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_addr_unit import sm83_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  ab_sel_t           ab_sel,
    input  logic [ADDR_W-1:0] hl,
    input  logic [ADDR_W-1:0] wz,
    input  logic              inc_pc,
    input  logic              load_pc,
    output logic [ADDR_W-1:0] addr
);

    logic [ADDR_W-1:0] pc;

    always_comb begin
        case (ab_sel)
            AB_HL:   addr = hl;
            AB_WZ:   addr = wz;
            default: addr = pc;
        endcase
    end

    // Program counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else if (load_pc) begin
            pc <= wz;               // Jump target
        end else if (inc_pc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/sm83_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_decoder import sm83_pkg::*; (
    input  logic [7:0] ir,
    input  step_t      step,
    output logic       done,
    output ab_sel_t    ab_sel,
    output reg8_t      s_db,
    output reg8_t      t_db,
    output r_wb_t      r_wb,
    output alu_op_t    alu_op,
    output acc_t       acc_sel,
    output arg_t       arg_sel,
    output logic       inc_pc,
    output logic       load_pc,
    output logic       write
);

    // (HL) forms of the kept patterns that run as NOP
    localparam logic [7:0] HALT      = 8'h76;
    localparam logic [7:0] LD_HL_N   = 8'b00110110;
    localparam logic [7:0] INCDEC_HL = 8'b0011010?;
    localparam logic [7:0] ALU_A_HL  = 8'b10???110;

    reg8_t r_dst;
    reg8_t r_src;

    function automatic reg8_t r8_decode(input logic [2:0] field);
        case (field)
            3'd0:    return B;
            3'd1:    return C;
            3'd2:    return D;
            3'd3:    return E;
            3'd4:    return H;
            3'd5:    return L;
            3'd7:    return A;
            default: return NONE;   // (HL) is filtered out before use
        endcase
    endfunction

    assign r_dst = r8_decode(ir[5:3]);
    assign r_src = r8_decode(ir[2:0]);
    assign write = (t_db == MEM);

    always_comb begin
        done    = 1'b0;
        ab_sel  = AB_PC;
        s_db    = NONE;
        t_db    = NONE;
        r_wb    = WB_DB;
        alu_op  = alu_op_t'(ir[5:3]);
        acc_sel = ACC_A;
        arg_sel = ARG_DB;
        inc_pc  = 1'b0;
        load_pc = 1'b0;

        casez ({ir, step})
            {NOP, 3'd0}, {HALT, 3'd0}, {LD_HL_N, 3'd0}, {INCDEC_HL, 3'd0}, {ALU_A_HL, 3'd0}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
            end
            {LD_R_N, 3'd0}, {ALU_A_N, 3'd0}, {JP_NN, 3'd0}: begin
                inc_pc = 1'b1;      // Immediate low byte into Z
                s_db   = MEM;
                t_db   = Z;
            end
            {LD_R_N, 3'd1}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
                s_db   = Z;
                t_db   = r_dst;
            end
            {INCDEC_R, 3'd0}: begin
                done    = 1'b1;
                inc_pc  = 1'b1;
                s_db    = r_dst;
                t_db    = r_dst;
                r_wb    = WB_ALU;
                acc_sel = ACC_DB;
                arg_sel = ARG_ONE;
                alu_op  = ir[0] ? ALU_SUB : ALU_ADD;
            end
            {LD_HL_R, 3'd0}: begin
                ab_sel = AB_HL;
                s_db   = r_src;
                t_db   = MEM;
            end
            {LD_R_HL, 3'd0}: begin
                ab_sel = AB_HL;
                s_db   = MEM;
                t_db   = Z;
            end
            {LD_R_HL, 3'd1}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
                s_db   = Z;
                t_db   = r_dst;
            end
            {LD_HL_R, 3'd1}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
            end
            {LD_R_R, 3'd0}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
                s_db   = r_src;
                t_db   = r_dst;
            end
            {ALU_A_R, 3'd0}, {ALU_A_N, 3'd1}: begin
                done   = 1'b1;
                inc_pc = 1'b1;
                s_db   = (ir[7:6] == 2'b11) ? Z : r_src;
                t_db   = (alu_op == ALU_CP) ? NONE : A;   // CP only updates flags
                r_wb   = WB_ALU;
            end
            {JP_NN, 3'd1}: begin
                inc_pc = 1'b1;
                s_db   = MEM;
                t_db   = W;
            end
            {JP_NN, 3'd2}: begin
                ab_sel  = AB_WZ;
                load_pc = 1'b1;
            end
            default: begin
                done   = 1'b1;      // Anything else behaves as NOP
                inc_pc = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sm83_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module sm83_sequencer import sm83_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              done,
    input  logic [DATA_W-1:0] d_in,
    output logic [7:0]        ir,
    output step_t             step
);

    // The last step of every instruction doubles as the next opcode fetch
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir   <= NOP;
            step <= '0;
        end else if (done) begin
            ir   <= d_in;       // Opcode arrives on the same cycle
            step <= '0;
        end else begin
            step <= step + 3'd1;
        end
    end

endmodule

`default_nettype wire

/* verilog/sm83_pkg.sv */
`default_nettype none

package sm83_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // Opcode patterns with ? bits as casez wildcards
    localparam logic [7:0] NOP      = 8'b00000000;
    localparam logic [7:0] LD_R_N   = 8'b00???110;
    localparam logic [7:0] INCDEC_R = 8'b00???10?;  // Bit 0 selects DEC
    localparam logic [7:0] LD_HL_R  = 8'b01110???;
    localparam logic [7:0] LD_R_HL  = 8'b01???110;
    localparam logic [7:0] LD_R_R   = 8'b01??????;
    localparam logic [7:0] ALU_A_R  = 8'b10??????;
    localparam logic [7:0] ALU_A_N  = 8'b11???110;
    localparam logic [7:0] JP_NN    = 8'b11000011;

    // 8-bit register or pseudo-register on the data bus
    typedef enum logic [3:0] {
        NONE = 4'h0,
        Z, W,                   // Temporaries for immediate operands
        B, C, D, E, H, L,
        A,
        MEM  = 4'hf             // External memory
    } reg8_t;

    typedef enum logic [1:0] {
        AB_PC,
        AB_HL,
        AB_WZ
    } ab_sel_t;

    typedef enum logic {
        WB_DB,
        WB_ALU
    } r_wb_t;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_t;

    typedef enum logic {
        ACC_A,
        ACC_DB
    } acc_t;

    typedef enum logic {
        ARG_DB,
        ARG_ONE
    } arg_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef logic [2:0] step_t;

endpackage

`default_nettype wire
